//--- design/core_pkg.sv
package core_pkg;

    // logical and physical register files
    localparam int LREG_NUM   = 32;
    localparam int LREG_WIDTH = 5;
    localparam int PREG_NUM   = 64;
    localparam int PREG_WIDTH = 6;

    // free list holds every physical register not mapped after reset
    localparam int FL_DEPTH     = PREG_NUM - LREG_NUM;
    localparam int FL_PTR_WIDTH = 5;
    localparam int FL_CNT_WIDTH = 6;

endpackage

//--- design/uop_pkg.sv
package uop_pkg;

    // fields that travel beside the register numbers
    localparam int PC_WIDTH    = 64;
    localparam int INSTR_WIDTH = 32;

endpackage

//--- design/hazardchecker.sv
module hazardchecker import core_pkg::*; (
    input  logic [LREG_WIDTH-1:0] instr0_lrd,
    input  logic                  instr0_lrd_valid,
    input  logic [LREG_WIDTH-1:0] instr1_lrs1,
    input  logic                  instr1_lrs1_valid,
    input  logic [LREG_WIDTH-1:0] instr1_lrs2,
    input  logic                  instr1_lrs2_valid,
    input  logic [LREG_WIDTH-1:0] instr1_lrd,
    input  logic                  instr1_lrd_valid,
    output logic                  raw_hazard_rs1,
    output logic                  raw_hazard_rs2,
    output logic                  waw_hazard
);

    logic instr0_wr;

    // x0 is hardwired, so it never links the two instructions
    assign instr0_wr = instr0_lrd_valid && (instr0_lrd != '0);

    // instr1 sources that depend on instr0 result
    assign raw_hazard_rs1 = instr0_wr && instr1_lrs1_valid && (instr1_lrs1 == instr0_lrd);
    assign raw_hazard_rs2 = instr0_wr && instr1_lrs2_valid && (instr1_lrs2 == instr0_lrd);

    // both write the same logical register
    assign waw_hazard = instr0_wr && instr1_lrd_valid && (instr1_lrd == instr0_lrd);

endmodule

//--- design/rename.sv
module rename import core_pkg::*, uop_pkg::*; (
    // decoded pair
    input  logic                   instr0_valid,
    input  logic [INSTR_WIDTH-1:0] instr0,
    input  logic [PC_WIDTH-1:0]    instr0_pc,
    input  logic [LREG_WIDTH-1:0]  instr0_lrs1,
    input  logic [LREG_WIDTH-1:0]  instr0_lrs2,
    input  logic [LREG_WIDTH-1:0]  instr0_lrd,
    input  logic                   instr0_src1_is_reg,
    input  logic                   instr0_src2_is_reg,
    input  logic                   instr0_need_to_wb,
    input  logic                   instr1_valid,
    input  logic [INSTR_WIDTH-1:0] instr1,
    input  logic [PC_WIDTH-1:0]    instr1_pc,
    input  logic [LREG_WIDTH-1:0]  instr1_lrs1,
    input  logic [LREG_WIDTH-1:0]  instr1_lrs2,
    input  logic [LREG_WIDTH-1:0]  instr1_lrd,
    input  logic                   instr1_src1_is_reg,
    input  logic                   instr1_src2_is_reg,
    input  logic                   instr1_need_to_wb,
    input  logic                   flush_valid,
    input  logic                   instr_ready,
    // spec_rat lookups
    output logic                   rn2specrat_instr0_lrs1_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr0_lrs1,
    output logic                   rn2specrat_instr0_lrs2_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr0_lrs2,
    output logic                   rn2specrat_instr0_lrd_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr0_lrd,
    output logic                   rn2specrat_instr1_lrs1_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr1_lrs1,
    output logic                   rn2specrat_instr1_lrs2_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr1_lrs2,
    output logic                   rn2specrat_instr1_lrd_rden,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr1_lrd,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr0prs1,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr0prs2,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr0prd,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr1prs1,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr1prs2,
    input  logic [PREG_WIDTH-1:0]  specrat2rn_instr1prd,
    // spec_rat updates
    output logic                   rn2specrat_instr0_lrd_wren,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr0_lrd_wraddr,
    output logic [PREG_WIDTH-1:0]  rn2specrat_instr0_lrd_wrdata,
    output logic                   rn2specrat_instr1_lrd_wren,
    output logic [LREG_WIDTH-1:0]  rn2specrat_instr1_lrd_wraddr,
    output logic [PREG_WIDTH-1:0]  rn2specrat_instr1_lrd_wrdata,
    // free list pops
    output logic                   rn2fl_instr0_lrd_valid,
    output logic                   rn2fl_instr1_lrd_valid,
    input  logic [PREG_WIDTH-1:0]  fl2rn_instr0prd,
    input  logic [PREG_WIDTH-1:0]  fl2rn_instr1prd,
    // renamed pair
    output logic                   rn_instr0_valid,
    output logic [PC_WIDTH-1:0]    rn_instr0_pc,
    output logic [INSTR_WIDTH-1:0] rn_instr0,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prs1,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prs2,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prd,
    output logic [PREG_WIDTH-1:0]  rn_instr0_old_prd,
    output logic                   rn_instr1_valid,
    output logic [PC_WIDTH-1:0]    rn_instr1_pc,
    output logic [INSTR_WIDTH-1:0] rn_instr1,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prs1,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prs2,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prd,
    output logic [PREG_WIDTH-1:0]  rn_instr1_old_prd
);

    logic instr0_lrs1_valid;
    logic instr0_lrs2_valid;
    logic instr0_lrd_valid;
    logic instr1_lrs1_valid;
    logic instr1_lrs2_valid;
    logic instr1_lrd_valid;
    logic raw_hazard_rs1;
    logic raw_hazard_rs2;
    logic waw_hazard;
    logic rename_en;

    assign instr0_lrs1_valid = instr0_valid && instr0_src1_is_reg;
    assign instr0_lrs2_valid = instr0_valid && instr0_src2_is_reg;
    assign instr0_lrd_valid  = instr0_valid && instr0_need_to_wb;
    assign instr1_lrs1_valid = instr1_valid && instr1_src1_is_reg;
    assign instr1_lrs2_valid = instr1_valid && instr1_src2_is_reg;
    assign instr1_lrd_valid  = instr1_valid && instr1_need_to_wb;

    hazardchecker u_hazardchecker (.*);

    // nothing is consumed or mapped under back-pressure or flush
    assign rename_en = instr_ready && !flush_valid;

    assign rn2specrat_instr0_lrs1_rden = instr0_lrs1_valid;
    assign rn2specrat_instr0_lrs1      = instr0_lrs1;
    assign rn2specrat_instr0_lrs2_rden = instr0_lrs2_valid;
    assign rn2specrat_instr0_lrs2      = instr0_lrs2;
    assign rn2specrat_instr0_lrd_rden  = instr0_lrd_valid;
    assign rn2specrat_instr0_lrd       = instr0_lrd;
    assign rn2specrat_instr1_lrs1_rden = instr1_lrs1_valid;
    assign rn2specrat_instr1_lrs1      = instr1_lrs1;
    assign rn2specrat_instr1_lrs2_rden = instr1_lrs2_valid;
    assign rn2specrat_instr1_lrs2      = instr1_lrs2;
    assign rn2specrat_instr1_lrd_rden  = instr1_lrd_valid;
    assign rn2specrat_instr1_lrd       = instr1_lrd;

    assign rn2fl_instr0_lrd_valid = instr0_lrd_valid && rename_en;
    assign rn2fl_instr1_lrd_valid = instr1_lrd_valid && rename_en;

    // on waw only instr1 mapping survives in the table
    assign rn2specrat_instr0_lrd_wren   = rn2fl_instr0_lrd_valid && !waw_hazard;
    assign rn2specrat_instr0_lrd_wraddr = instr0_lrd;
    assign rn2specrat_instr0_lrd_wrdata = fl2rn_instr0prd;
    assign rn2specrat_instr1_lrd_wren   = rn2fl_instr1_lrd_valid;
    assign rn2specrat_instr1_lrd_wraddr = instr1_lrd;
    assign rn2specrat_instr1_lrd_wrdata = fl2rn_instr1prd;

    assign rn_instr0_valid   = instr0_valid && rename_en;
    assign rn_instr0_pc      = instr0_pc;
    assign rn_instr0         = instr0;
    assign rn_instr0_prs1    = specrat2rn_instr0prs1;
    assign rn_instr0_prs2    = specrat2rn_instr0prs2;
    assign rn_instr0_prd     = instr0_lrd_valid ? fl2rn_instr0prd : '0;
    assign rn_instr0_old_prd = instr0_lrd_valid ? specrat2rn_instr0prd : '0;

    // instr0 new destination is forwarded past the table to instr1
    assign rn_instr1_valid   = instr1_valid && rename_en;
    assign rn_instr1_pc      = instr1_pc;
    assign rn_instr1         = instr1;
    assign rn_instr1_prs1    = raw_hazard_rs1 ? fl2rn_instr0prd : specrat2rn_instr1prs1;
    assign rn_instr1_prs2    = raw_hazard_rs2 ? fl2rn_instr0prd : specrat2rn_instr1prs2;
    assign rn_instr1_prd     = instr1_lrd_valid ? fl2rn_instr1prd : '0;
    // previous mapping of a shared destination is the one instr0 just took
    assign rn_instr1_old_prd = !instr1_lrd_valid ? '0 :
                               waw_hazard ? fl2rn_instr0prd : specrat2rn_instr1prd;

endmodule

//--- design/spec_rat.sv
module spec_rat import core_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  rn2specrat_instr0_lrs1_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr0_lrs1,
    input  logic                  rn2specrat_instr0_lrs2_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr0_lrs2,
    input  logic                  rn2specrat_instr0_lrd_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr0_lrd,
    input  logic                  rn2specrat_instr1_lrs1_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr1_lrs1,
    input  logic                  rn2specrat_instr1_lrs2_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr1_lrs2,
    input  logic                  rn2specrat_instr1_lrd_rden,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr1_lrd,
    input  logic                  rn2specrat_instr0_lrd_wren,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr0_lrd_wraddr,
    input  logic [PREG_WIDTH-1:0] rn2specrat_instr0_lrd_wrdata,
    input  logic                  rn2specrat_instr1_lrd_wren,
    input  logic [LREG_WIDTH-1:0] rn2specrat_instr1_lrd_wraddr,
    input  logic [PREG_WIDTH-1:0] rn2specrat_instr1_lrd_wrdata,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr0prs1,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr0prs2,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr0prd,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr1prs1,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr1prs2,
    output logic [PREG_WIDTH-1:0] specrat2rn_instr1prd
);

    logic [PREG_WIDTH-1:0] rat [LREG_NUM];

    // unused lookups read as p0
    assign specrat2rn_instr0prs1 = rn2specrat_instr0_lrs1_rden ? rat[rn2specrat_instr0_lrs1] : '0;
    assign specrat2rn_instr0prs2 = rn2specrat_instr0_lrs2_rden ? rat[rn2specrat_instr0_lrs2] : '0;
    assign specrat2rn_instr0prd  = rn2specrat_instr0_lrd_rden ? rat[rn2specrat_instr0_lrd] : '0;
    assign specrat2rn_instr1prs1 = rn2specrat_instr1_lrs1_rden ? rat[rn2specrat_instr1_lrs1] : '0;
    assign specrat2rn_instr1prs2 = rn2specrat_instr1_lrs2_rden ? rat[rn2specrat_instr1_lrs2] : '0;
    assign specrat2rn_instr1prd  = rn2specrat_instr1_lrd_rden ? rat[rn2specrat_instr1_lrd] : '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // identity mapping, r maps to p(r)
            for (int i = 0; i < LREG_NUM; i++) begin
                rat[i] <= PREG_WIDTH'(i);
            end
        end else begin
            if (rn2specrat_instr0_lrd_wren) begin
                rat[rn2specrat_instr0_lrd_wraddr] <= rn2specrat_instr0_lrd_wrdata;
            end
            // port 1 is younger and overrides port 0
            if (rn2specrat_instr1_lrd_wren) begin
                rat[rn2specrat_instr1_lrd_wraddr] <= rn2specrat_instr1_lrd_wrdata;
            end
        end
    end

endmodule

//--- design/freelist.sv
module freelist import core_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    rn2fl_instr0_lrd_valid,
    input  logic                    rn2fl_instr1_lrd_valid,
    input  logic                    release_valid,
    input  logic [PREG_WIDTH-1:0]   release_preg,
    output logic [PREG_WIDTH-1:0]   fl2rn_instr0prd,
    output logic [PREG_WIDTH-1:0]   fl2rn_instr1prd,
    output logic [FL_CNT_WIDTH-1:0] free_count
);

    logic [PREG_WIDTH-1:0]   fifo [FL_DEPTH];
    logic [FL_PTR_WIDTH-1:0] head;
    logic [FL_PTR_WIDTH-1:0] tail;
    logic [FL_PTR_WIDTH-1:0] head_next;
    logic [1:0]              pop_num;

    // pointers wrap on their own since depth is a power of two
    assign head_next = head + FL_PTR_WIDTH'(1);
    assign pop_num   = {1'b0, rn2fl_instr0_lrd_valid} + {1'b0, rn2fl_instr1_lrd_valid};

    // instr1 skips the head entry when instr0 takes it
    assign fl2rn_instr0prd = fifo[head];
    assign fl2rn_instr1prd = rn2fl_instr0_lrd_valid ? fifo[head_next] : fifo[head];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // p32..p63 are free, queue starts full
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo[i] <= PREG_WIDTH'(LREG_NUM + i);
            end
            head       <= '0;
            tail       <= '0;
            free_count <= FL_CNT_WIDTH'(FL_DEPTH);
        end else begin
            head <= head + FL_PTR_WIDTH'(pop_num);
            if (release_valid) begin
                fifo[tail] <= release_preg;
                tail       <= tail + FL_PTR_WIDTH'(1);
            end
            free_count <= free_count + FL_CNT_WIDTH'(release_valid) - FL_CNT_WIDTH'(pop_num);
        end
    end

endmodule

//--- design/rename_top.sv
module rename_top import core_pkg::*, uop_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   instr0_valid,
    input  logic [INSTR_WIDTH-1:0] instr0,
    input  logic [PC_WIDTH-1:0]    instr0_pc,
    input  logic [LREG_WIDTH-1:0]  instr0_lrs1,
    input  logic [LREG_WIDTH-1:0]  instr0_lrs2,
    input  logic [LREG_WIDTH-1:0]  instr0_lrd,
    input  logic                   instr0_src1_is_reg,
    input  logic                   instr0_src2_is_reg,
    input  logic                   instr0_need_to_wb,
    input  logic                   instr1_valid,
    input  logic [INSTR_WIDTH-1:0] instr1,
    input  logic [PC_WIDTH-1:0]    instr1_pc,
    input  logic [LREG_WIDTH-1:0]  instr1_lrs1,
    input  logic [LREG_WIDTH-1:0]  instr1_lrs2,
    input  logic [LREG_WIDTH-1:0]  instr1_lrd,
    input  logic                   instr1_src1_is_reg,
    input  logic                   instr1_src2_is_reg,
    input  logic                   instr1_need_to_wb,
    input  logic                   disp_ready,
    input  logic                   flush_valid,
    input  logic                   release_valid,
    input  logic [PREG_WIDTH-1:0]  release_preg,
    output logic                   instr_ready,
    output logic                   rn_instr0_valid,
    output logic [PC_WIDTH-1:0]    rn_instr0_pc,
    output logic [INSTR_WIDTH-1:0] rn_instr0,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prs1,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prs2,
    output logic [PREG_WIDTH-1:0]  rn_instr0_prd,
    output logic [PREG_WIDTH-1:0]  rn_instr0_old_prd,
    output logic                   rn_instr1_valid,
    output logic [PC_WIDTH-1:0]    rn_instr1_pc,
    output logic [INSTR_WIDTH-1:0] rn_instr1,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prs1,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prs2,
    output logic [PREG_WIDTH-1:0]  rn_instr1_prd,
    output logic [PREG_WIDTH-1:0]  rn_instr1_old_prd
);

    // spec_rat lookup and update ports
    logic                    rn2specrat_instr0_lrs1_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr0_lrs1;
    logic                    rn2specrat_instr0_lrs2_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr0_lrs2;
    logic                    rn2specrat_instr0_lrd_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr0_lrd;
    logic                    rn2specrat_instr1_lrs1_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr1_lrs1;
    logic                    rn2specrat_instr1_lrs2_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr1_lrs2;
    logic                    rn2specrat_instr1_lrd_rden;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr1_lrd;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr0prs1;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr0prs2;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr0prd;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr1prs1;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr1prs2;
    logic [PREG_WIDTH-1:0]   specrat2rn_instr1prd;
    logic                    rn2specrat_instr0_lrd_wren;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr0_lrd_wraddr;
    logic [PREG_WIDTH-1:0]   rn2specrat_instr0_lrd_wrdata;
    logic                    rn2specrat_instr1_lrd_wren;
    logic [LREG_WIDTH-1:0]   rn2specrat_instr1_lrd_wraddr;
    logic [PREG_WIDTH-1:0]   rn2specrat_instr1_lrd_wrdata;
    // free list ports
    logic                    rn2fl_instr0_lrd_valid;
    logic                    rn2fl_instr1_lrd_valid;
    logic [PREG_WIDTH-1:0]   fl2rn_instr0prd;
    logic [PREG_WIDTH-1:0]   fl2rn_instr1prd;
    logic [FL_CNT_WIDTH-1:0] free_count;

    // two free entries are needed so either slot can always allocate
    assign instr_ready = disp_ready && (free_count >= FL_CNT_WIDTH'(2));

    rename u_rename (.*);

    spec_rat u_spec_rat (.*);

    freelist u_freelist (.*);

endmodule

//--- dv/rename_chk.sv
module rename_chk import core_pkg::*; (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    instr_ready,
    input logic                    rn2fl_instr0_lrd_valid,
    input logic                    rn2fl_instr1_lrd_valid,
    input logic [PREG_WIDTH-1:0]   fl2rn_instr0prd,
    input logic [PREG_WIDTH-1:0]   fl2rn_instr1prd,
    input logic [FL_CNT_WIDTH-1:0] free_count
);

    int violations = 0;

    a_no_pop_stalled: assert property (@(posedge clock) disable iff (!rst_n)
        !instr_ready |-> !(rn2fl_instr0_lrd_valid || rn2fl_instr1_lrd_valid))
        else begin
            $error("free list popped while instr_ready is low");
            violations++;
        end

    a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        free_count <= FL_CNT_WIDTH'(FL_DEPTH))
        else begin
            $error("free_count is above the free list depth");
            violations++;
        end

    // a double pop must hand out two different registers
    a_distinct_prd: assert property (@(posedge clock) disable iff (!rst_n)
        (rn2fl_instr0_lrd_valid && rn2fl_instr1_lrd_valid) |->
        (fl2rn_instr0prd != fl2rn_instr1prd))
        else begin
            $error("both instructions received the same prd");
            violations++;
        end

endmodule

bind rename_top rename_chk u_rename_chk (
    .clock                  (clock),
    .rst_n                  (rst_n),
    .instr_ready            (instr_ready),
    .rn2fl_instr0_lrd_valid (rn2fl_instr0_lrd_valid),
    .rn2fl_instr1_lrd_valid (rn2fl_instr1_lrd_valid),
    .fl2rn_instr0prd        (fl2rn_instr0prd),
    .fl2rn_instr1prd        (fl2rn_instr1prd),
    .free_count             (free_count)
);

//--- dv/tb_rename.sv
module tb_rename import core_pkg::*, uop_pkg::*; ();

    localparam int MAX_CYCLES = 2000;

    logic clock;
    logic rst_n;
    logic instr0_valid, instr0_src1_is_reg, instr0_src2_is_reg, instr0_need_to_wb;
    logic instr1_valid, instr1_src1_is_reg, instr1_src2_is_reg, instr1_need_to_wb;
    logic [INSTR_WIDTH-1:0] instr0, instr1;
    logic [PC_WIDTH-1:0]    instr0_pc, instr1_pc;
    logic [LREG_WIDTH-1:0]  instr0_lrs1, instr0_lrs2, instr0_lrd;
    logic [LREG_WIDTH-1:0]  instr1_lrs1, instr1_lrs2, instr1_lrd;
    logic disp_ready, flush_valid, release_valid;
    logic [PREG_WIDTH-1:0]  release_preg;
    logic instr_ready, rn_instr0_valid, rn_instr1_valid;
    logic [PC_WIDTH-1:0]    rn_instr0_pc, rn_instr1_pc;
    logic [INSTR_WIDTH-1:0] rn_instr0, rn_instr1;
    logic [PREG_WIDTH-1:0]  rn_instr0_prs1, rn_instr0_prs2, rn_instr0_prd, rn_instr0_old_prd;
    logic [PREG_WIDTH-1:0]  rn_instr1_prs1, rn_instr1_prs2, rn_instr1_prd, rn_instr1_old_prd;

    // reference alias table, free queue and registers waiting for release
    logic [PREG_WIDTH-1:0] ref_rat [LREG_NUM];
    logic [PREG_WIDTH-1:0] free_q [$];
    logic [PREG_WIDTH-1:0] retire_q [$];
    // next pair to drive for each slot
    logic                  s_valid [2], s_r1 [2], s_r2 [2], s_wb [2];
    logic [LREG_WIDTH-1:0] s_lrs1 [2], s_lrs2 [2], s_lrd [2];
    logic                  s_disp, s_flush, s_rel;
    logic [PREG_WIDTH-1:0] s_rel_preg;
    logic [PC_WIDTH-1:0]   s_pc;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed = 32'hc13d_17af;

    rename_top uut (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_preg(input logic [PREG_WIDTH-1:0] got,
                              input logic [PREG_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input logic [PC_WIDTH-1:0] got,
                            input logic [PC_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [INSTR_WIDTH-1:0] got,
                              input logic [INSTR_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic set_slot(input int s, input logic v, input logic [LREG_WIDTH-1:0] lrs1,
                            input logic [LREG_WIDTH-1:0] lrs2, input logic [LREG_WIDTH-1:0] lrd,
                            input logic r1, input logic r2, input logic wb);
        s_valid[s] = v;
        s_lrs1[s]  = lrs1;
        s_lrs2[s]  = lrs2;
        s_lrd[s]   = lrd;
        s_r1[s]    = r1;
        s_r2[s]    = r2;
        s_wb[s]    = wb;
    endtask

    task automatic stage_release();
        if (retire_q.size() > 0) begin
            s_rel      = 1'b1;
            s_rel_preg = retire_q.pop_front();
        end
    endtask

    // drive one pair, compare at the falling edge, then advance the model
    task automatic run_cycle();
        logic [PREG_WIDTH-1:0] prd [2];
        logic [PREG_WIDTH-1:0] old [2];
        logic [PREG_WIDTH-1:0] prs1 [2];
        logic [PREG_WIDTH-1:0] prs2 [2];
        logic                  wb [2];
        logic                  ready;
        logic                  fire;
        int                    used;
        @(posedge clock);
        {instr0_valid, instr0_src1_is_reg, instr0_src2_is_reg, instr0_need_to_wb} <=
            {s_valid[0], s_r1[0], s_r2[0], s_wb[0]};
        {instr0_lrs1, instr0_lrs2, instr0_lrd} <= {s_lrs1[0], s_lrs2[0], s_lrd[0]};
        {instr1_valid, instr1_src1_is_reg, instr1_src2_is_reg, instr1_need_to_wb} <=
            {s_valid[1], s_r1[1], s_r2[1], s_wb[1]};
        {instr1_lrs1, instr1_lrs2, instr1_lrd} <= {s_lrs1[1], s_lrs2[1], s_lrd[1]};
        {disp_ready, flush_valid, release_valid} <= {s_disp, s_flush, s_rel};
        release_preg <= s_rel_preg;
        // a fresh pc and word every cycle so the pass-through is visible
        instr0_pc <= s_pc;
        instr1_pc <= s_pc + PC_WIDTH'(4);
        instr0    <= {s_pc[31:2], 2'b11};
        instr1    <= {~s_pc[31:2], 2'b11};
        @(negedge clock);
        ready = s_disp && (free_q.size() >= 2);
        fire  = ready && !s_flush;
        used  = 0;
        for (int i = 0; i < 2; i++) begin
            wb[i]   = s_valid[i] && s_wb[i];
            prd[i]  = '0;
            if (wb[i] && used < free_q.size()) begin
                prd[i] = free_q[used];
                used++;
            end
            old[i]  = wb[i] ? ref_rat[s_lrd[i]] : '0;
            prs1[i] = (s_valid[i] && s_r1[i]) ? ref_rat[s_lrs1[i]] : '0;
            prs2[i] = (s_valid[i] && s_r2[i]) ? ref_rat[s_lrs2[i]] : '0;
        end
        // instr1 sees the destination instr0 takes in this cycle unless it is x0
        if (wb[0] && s_lrd[0] != '0) begin
            if (s_valid[1] && s_r1[1] && s_lrs1[1] == s_lrd[0]) prs1[1] = prd[0];
            if (s_valid[1] && s_r2[1] && s_lrs2[1] == s_lrd[0]) prs2[1] = prd[0];
            if (wb[1] && s_lrd[1] == s_lrd[0]) old[1] = prd[0];
        end
        check_bit(instr_ready, ready, "instr_ready");
        check_bit(rn_instr0_valid, s_valid[0] && fire, "rn_instr0_valid");
        check_bit(rn_instr1_valid, s_valid[1] && fire, "rn_instr1_valid");
        if (s_valid[0] && fire) begin
            check_pc(rn_instr0_pc, s_pc, "instr0 pc");
            check_word(rn_instr0, {s_pc[31:2], 2'b11}, "instr0 word");
            check_preg(rn_instr0_prs1, prs1[0], "instr0 prs1");
            check_preg(rn_instr0_prs2, prs2[0], "instr0 prs2");
            check_preg(rn_instr0_prd, prd[0], "instr0 prd");
            check_preg(rn_instr0_old_prd, old[0], "instr0 old_prd");
        end
        if (s_valid[1] && fire) begin
            check_pc(rn_instr1_pc, s_pc + PC_WIDTH'(4), "instr1 pc");
            check_word(rn_instr1, {~s_pc[31:2], 2'b11}, "instr1 word");
            check_preg(rn_instr1_prs1, prs1[1], "instr1 prs1");
            check_preg(rn_instr1_prs2, prs2[1], "instr1 prs2");
            check_preg(rn_instr1_prd, prd[1], "instr1 prd");
            check_preg(rn_instr1_old_prd, old[1], "instr1 old_prd");
        end
        // the younger write lands last just like in the table
        for (int i = 0; i < 2; i++) begin
            if (fire && wb[i]) begin
                void'(free_q.pop_front());
                ref_rat[s_lrd[i]] = prd[i];
                retire_q.push_back(old[i]);
            end
        end
        if (s_rel) free_q.push_back(s_rel_preg);
        s_rel = 1'b0;
        s_pc  = s_pc + PC_WIDTH'(8);
    endtask

    task automatic test_reset_singles();
        for (int k = 0; k < 6; k++) begin
            set_slot(k / 4, 1, LREG_WIDTH'(k), LREG_WIDTH'(k + 7), LREG_WIDTH'(k + 1), 1, 1, 1);
            set_slot(1 - k / 4, 0, 0, 0, 0, 0, 0, 0);
            run_cycle();
        end
    endtask

    task automatic test_raw_pair();
        set_slot(0, 1, 3, 4, 10, 1, 1, 1);
        set_slot(1, 1, 10, 10, 11, 1, 1, 1);
        run_cycle();
        set_slot(1, 1, 5, 10, 12, 1, 1, 1);
        run_cycle();
        // x0 as a destination links nothing
        set_slot(0, 1, 1, 2, 0, 1, 1, 1);
        set_slot(1, 1, 0, 0, 13, 1, 1, 1);
        run_cycle();
    endtask

    task automatic test_waw_pair();
        set_slot(0, 1, 1, 2, 14, 1, 1, 1);
        set_slot(1, 1, 3, 14, 14, 1, 1, 1);
        run_cycle();
        set_slot(0, 1, 14, 14, 15, 1, 1, 1);
        set_slot(1, 0, 0, 0, 0, 0, 0, 0);
        run_cycle();
    endtask

    task automatic test_backpressure();
        s_disp = 1'b0;
        set_slot(0, 1, 1, 2, 3, 1, 1, 1);
        set_slot(1, 1, 4, 5, 6, 1, 1, 1);
        run_cycle();
        run_cycle();
        s_disp = 1'b1;
        // drain the free list until instr_ready drops
        while (free_q.size() >= 2) begin
            run_cycle();
        end
        run_cycle();
    endtask

    task automatic test_flush_release();
        set_slot(0, 0, 0, 0, 0, 0, 0, 0);
        set_slot(1, 0, 0, 0, 0, 0, 0, 0);
        repeat (4) begin
            stage_release();
            run_cycle();
        end
        // the flushed pair targets x1, whose mapping the next cycle looks up
        s_flush = 1'b1;
        set_slot(0, 1, 7, 8, 1, 1, 1, 1);
        set_slot(1, 1, 1, 7, 1, 1, 1, 1);
        run_cycle();
        s_flush = 1'b0;
        set_slot(1, 0, 0, 0, 0, 0, 0, 0);
        for (int k = 0; k < 40; k++) begin
            set_slot(0, 1, LREG_WIDTH'(k % 8), LREG_WIDTH'(k % 5), LREG_WIDTH'(k % 7 + 1), 1, 1, 1);
            stage_release();
            run_cycle();
        end
    endtask

    task automatic test_random_pairs();
        logic [31:0] r;
        for (int n = 0; n < 150; n++) begin
            for (int s = 0; s < 2; s++) begin
                r = $random(seed);
                set_slot(s, r[0] | r[1], LREG_WIDTH'(r[4:2]), LREG_WIDTH'(r[7:5]),
                         LREG_WIDTH'(r[10:8]), r[11], r[12], r[13] | r[14]);
            end
            r = $random(seed);
            s_disp  = r[3:0] != 4'd0;
            s_flush = r[7:4] == 4'd0;
            if (r[9:8] != 2'd0) stage_release();
            run_cycle();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        {instr0_valid, instr0_src1_is_reg, instr0_src2_is_reg, instr0_need_to_wb} = '0;
        {instr1_valid, instr1_src1_is_reg, instr1_src2_is_reg, instr1_need_to_wb} = '0;
        {instr0_lrs1, instr0_lrs2, instr0_lrd, instr1_lrs1, instr1_lrs2, instr1_lrd} = '0;
        {disp_ready, flush_valid, release_valid, release_preg} = '0;
        instr0    = 32'h0010_0093;
        instr1    = 32'h0020_8133;
        instr0_pc = 64'h8000_0000;
        instr1_pc = 64'h8000_0004;
        s_pc      = 64'h8000_0000;
        for (int i = 0; i < LREG_NUM; i++) ref_rat[i] = PREG_WIDTH'(i);
        for (int i = 0; i < FL_DEPTH; i++) free_q.push_back(PREG_WIDTH'(LREG_NUM + i));
        {s_disp, s_flush, s_rel, s_rel_preg} = {1'b1, 1'b0, 1'b0, 6'd0};
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        test_reset_singles();
        test_raw_pair();
        test_waw_pair();
        test_backpressure();
        test_flush_release();
        test_random_pairs();
        @(negedge clock);
        errors += uut.u_rename_chk.violations;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 uut.u_rename_chk.violations);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/core_pkg.sv
design/uop_pkg.sv
design/hazardchecker.sv
design/rename.sv
design/spec_rat.sv
design/freelist.sv
design/rename_top.sv
dv/rename_chk.sv
dv/tb_rename.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_rename -f vlog.f -o tb_rename; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_rename +verilator+error+limit+100 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
